// ==== dv/fetch_frontend_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_checker import isa_pkg::*; (
    input wire          clk,
    input wire          i_arst_n,
    input wire          i_imem_req,
    input wire addr_t   i_imem_addr,
    input wire          i_imem_ready,
    input wire          i_br_valid,
    input wire addr_t   i_br_target,
    input wire addr_t   i_pc1,
    input wire inst_t   i_ir1,
    input wire addr_t   i_pc2,
    input wire inst_t   i_ir2,
    input wire [1:0]    i_valid,
    input wire          i_full
);

    int fail_cnt = 0;   // read by the testbench after each test

    ////////////////////
    // request side

    // stalled request keeps its address unless redirected
    stall_addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_imem_req && !i_imem_ready && !i_br_valid |=> $stable(i_imem_addr))
        else begin
            $error("fetch address changed while the request was stalled");
            fail_cnt = fail_cnt + 1;
        end

    req_low_when_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_full |-> !i_imem_req)
        else begin
            $error("request raised while the buffer is full");
            fail_cnt = fail_cnt + 1;
        end

    ////////////////////
    // decoder side

    // memory model returns the inverted address as the word
    ir1_matches_pc: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid[0] |-> i_ir1 == ~i_pc1)
        else begin
            $error("head instruction does not belong to its pc");
            fail_cnt = fail_cnt + 1;
        end

    ir2_matches_pc: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid[1] |-> i_ir2 == ~i_pc2)
        else begin
            $error("second instruction does not belong to its pc");
            fail_cnt = fail_cnt + 1;
        end

    pc2_follows_pc1: assert property (@(posedge clk) disable iff (!i_arst_n)
        &i_valid |-> i_pc2 == i_pc1 + 32'd4)
        else begin
            $error("second head pc is not 4 above the first");
            fail_cnt = fail_cnt + 1;
        end

    valid_in_order: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid != 2'b10)
        else begin
            $error("second slot valid without the first");
            fail_cnt = fail_cnt + 1;
        end

    // redirect empties the buffer and moves fetch in one edge
    branch_redirect: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_br_valid |=> i_valid == 2'b00 && i_imem_addr == $past(i_br_target))
        else begin
            $error("branch did not flush the buffer and load the target");
            fail_cnt = fail_cnt + 1;
        end

endmodule

`default_nettype wire

// ==== dv/fetch_frontend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb import isa_pkg::*, frontend_pkg::*; ();

    // 5 tests of at most 250 cycles plus margin
    localparam int    TIMEOUT_CYCLES = 1500;
    localparam addr_t LAST_WORD_TGT  = 32'h1c00_200c;  // bits 3:2 == 3
    localparam addr_t BRANCH_TGT     = 32'h1c00_3000;

    logic              clk        = 1'b0;
    logic              arst_n     = 1'b0;
    logic              imem_ready = 1'b0;
    logic [2*XLEN-1:0] imem_rdata = '0;
    logic              br_valid   = 1'b0;
    addr_t             br_target  = '0;
    take_t             dec_take   = '0;
    wire               imem_req;
    wire addr_t        imem_addr;
    wire addr_t        pc1;
    wire addr_t        pc2;
    wire inst_t        ir1;
    wire inst_t        ir2;
    wire [1:0]         valid;
    wire               full;

    logic [31:0] rand_state = 32'd81930;
    addr_t       exp_pc     = RESET_PC;    // next pc the decoder should take
    int          cycle_cnt  = 0;
    int          err_cnt    = 0;
    int          taken_cnt  = 0;
    int          err_mark   = 0;
    int          taken_mark = 0;
    int          total_err;
    bit          saw_full;
    bit          first_seen;

    always #50 clk = ~clk;

    fetch_frontend uut (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .i_imem_ready (imem_ready),
        .i_imem_rdata (imem_rdata),
        .i_br_valid   (br_valid),
        .i_br_target  (br_target),
        .o_pc1        (pc1),
        .o_ir1        (ir1),
        .o_pc2        (pc2),
        .o_ir2        (ir2),
        .o_valid      (valid),
        .i_dec_take   (dec_take),
        .o_full       (full)
    );

    bind fetch_frontend fetch_frontend_checker chk (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_imem_req   (o_imem_req),
        .i_imem_addr  (o_imem_addr),
        .i_imem_ready (i_imem_ready),
        .i_br_valid   (i_br_valid),
        .i_br_target  (i_br_target),
        .i_pc1        (o_pc1),
        .i_ir1        (o_ir1),
        .i_pc2        (o_pc2),
        .i_ir2        (o_ir2),
        .i_valid      (o_valid),
        .i_full       (o_full)
    );

    ////////////////////
    // memory model and timeout

    // word pair one cycle after accept with each word the inverse of its address
    always @(posedge clk) begin
        if (imem_req && imem_ready) begin
            imem_rdata <= {~(imem_addr + 32'd4), ~imem_addr};
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    ////////////////////
    // per-cycle driver

    task automatic check_slot(input addr_t pc, input inst_t ir, input int slot);
        if (pc !== exp_pc || ir !== ~exp_pc) begin
            $display("Mismatch at %0t: slot %0d took pc %h ir %h, expected pc %h ir %h",
                     $time, slot, pc, ir, exp_pc, ~exp_pc);
            err_cnt++;
        end
        exp_pc = exp_pc + 32'd4;
        taken_cnt++;
    endtask

    // outputs read here still belong to the cycle that ends at this edge
    task automatic step(input bit rnd_ready, input bit hold, input bit br, input addr_t tgt);
        logic [31:0] r;
        int          avail;
        int          pick;
        @(posedge clk);
        if (br_valid) begin
            exp_pc = br_target;     // take was held at 0 across the flush edge
        end else if (dec_take != 2'd0) begin
            check_slot(pc1, ir1, 1);
            if (dec_take == 2'd2) begin
                check_slot(pc2, ir2, 2);
            end
        end
        // slots left after this edge's take are still there next cycle
        avail = br_valid ? 0 : int'(valid[0]) + int'(valid[1]) - int'(dec_take);
        r = next_rand();
        pick = int'(r[17:16]);
        if (pick > 2) pick = 2;
        if (pick > avail) pick = avail;
        if (br || hold) pick = 0;
        imem_ready <= rnd_ready ? (r[26:24] > 3'd1) : 1'b1;
        br_valid   <= br;
        br_target  <= tgt;
        dec_take   <= take_t'(pick);
    endtask

    task automatic test_done(input int num, input string name);
        int errs;
        @(negedge clk);
        errs = err_cnt + uut.chk.fail_cnt;
        $display("test %0d %s: %0d taken, %0d errors",
                 num, name, taken_cnt - taken_mark, errs - err_mark);
        err_mark   = errs;
        taken_mark = taken_cnt;
    endtask

    ////////////////////
    // test sequence

    initial begin
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        repeat (200) step(1'b0, 1'b0, 1'b0, '0);
        test_done(1, "sequential fetch");

        // single word at the end of the line and then a full pair
        step(1'b0, 1'b0, 1'b1, LAST_WORD_TGT);
        first_seen = 1'b0;
        while (!first_seen) begin
            step(1'b0, 1'b0, 1'b0, '0);
            if (!br_valid && valid[0]) begin
                first_seen = 1'b1;
                if (valid != 2'b01 || pc1 !== LAST_WORD_TGT) begin
                    $display("Mismatch at %0t: first head after branch valid %b pc %h",
                             $time, valid, pc1);
                    err_cnt++;
                end
            end
        end
        repeat (100) step(1'b0, 1'b0, 1'b0, '0);
        test_done(2, "branch to last word");

        repeat (200) step(1'b1, 1'b0, 1'b0, '0);
        test_done(3, "random ready");

        saw_full = 1'b0;
        repeat (60) begin
            step(1'b0, 1'b1, 1'b0, '0);
            if (full) saw_full = 1'b1;
        end
        if (!saw_full) begin
            $display("Full never rose while the decoder took nothing for 60 cycles");
            err_cnt++;
        end
        repeat (150) step(1'b0, 1'b0, 1'b0, '0);
        test_done(4, "full back-pressure");

        repeat (60) step(1'b0, 1'b0, 1'b0, '0);
        step(1'b0, 1'b0, 1'b1, BRANCH_TGT);
        repeat (120) step(1'b1, 1'b0, 1'b0, '0);
        test_done(5, "branch during fetch");

        total_err = err_cnt + uut.chk.fail_cnt;
        $display("tests 5, instructions taken %0d, errors %0d", taken_cnt, total_err);
        if (total_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module fetch_frontend_tb -o fetch_sim
./obj_dir/fetch_sim +verilator+error+limit+100 2>&1 | tee sim.log
if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== src.f ====
verilog/isa_pkg.sv
verilog/frontend_pkg.sv
verilog/fetch_if.sv
verilog/pc_gen.sv
verilog/fetch_stage.sv
verilog/inst_buffer.sv
verilog/fetch_frontend.sv
dv/fetch_frontend_checker.sv
dv/fetch_frontend_tb.sv

// ==== verilog/fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend import isa_pkg::*, frontend_pkg::*; (
    input  wire                 clk,
    input  wire                 i_arst_n,
    // instruction memory
    output logic                o_imem_req,
    output addr_t               o_imem_addr,
    input  wire                 i_imem_ready,
    input  wire [2*XLEN-1:0]    i_imem_rdata,
    // branch redirect
    input  wire                 i_br_valid,
    input  wire addr_t          i_br_target,
    // decoder
    output addr_t               o_pc1,
    output inst_t               o_ir1,
    output addr_t               o_pc2,
    output inst_t               o_ir2,
    output logic [1:0]          o_valid,
    input  wire take_t          i_dec_take,
    // status
    output logic                o_full
);

    logic       imem_accept;
    logic       fetch_pair;
    inst_slot_t head_a;
    inst_slot_t head_b;

    fetch_if fetch_bus ();

    assign imem_accept = o_imem_req & i_imem_ready;

    pc_gen pc_gen_inst (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_br_valid   (i_br_valid),
        .i_br_target  (i_br_target),
        .i_imem_ready (i_imem_ready),
        .i_full       (o_full),
        .o_imem_req   (o_imem_req),
        .o_pc         (o_imem_addr),
        .o_pair       (fetch_pair)
    );

    // branch pulse doubles as flush for the stage and the buffer
    fetch_stage fetch_stage_inst (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_accept     (imem_accept),
        .i_pc         (o_imem_addr),
        .i_pair       (fetch_pair),
        .i_flush      (i_br_valid),
        .i_imem_rdata (i_imem_rdata),
        .o_fetch      (fetch_bus.stage)
    );

    inst_buffer inst_buffer_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_fetch  (fetch_bus.buffer),
        .i_flush  (i_br_valid),
        .i_take   (i_dec_take),
        .o_head_a (head_a),
        .o_head_b (head_b),
        .o_valid  (o_valid),
        .o_full   (o_full)
    );

    // head slots out to the decoder
    assign o_pc1 = head_a.pc;
    assign o_ir1 = head_a.ir;
    assign o_pc2 = head_b.pc;
    assign o_ir2 = head_b.ir;

endmodule

`default_nettype wire

// ==== verilog/fetch_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// fetched word pair on its way into the instruction buffer
interface fetch_if import frontend_pkg::*; ();

    inst_slot_t slot_a;     // word at the fetch pc
    inst_slot_t slot_b;     // word at pc + 4
    logic [1:0] valid;      // bit 0 for slot a, one-cycle write strobes

    // fetch stage side
    modport stage (
        output slot_a,
        output slot_b,
        output valid
    );

    // buffer side
    modport buffer (
        input  slot_a,
        input  slot_b,
        input  valid
    );

endinterface

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import isa_pkg::*, frontend_pkg::*; (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  wire                 i_accept,       // request taken by imem this edge
    input  wire addr_t          i_pc,
    input  wire                 i_pair,
    input  wire                 i_flush,
    input  wire [2*XLEN-1:0]    i_imem_rdata,   // lower word at the request pc
    fetch_if.stage              o_fetch
);

    addr_t pc_q;
    logic  pair_q;
    logic  valid_q;
    inst_t ir_lo;
    inst_t ir_hi;

    ////////////////////
    // request tracking

    // one pair in flight at most, killed by a redirect
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_accept & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (i_accept) begin
            pc_q   <= i_pc;
            pair_q <= i_pair;
        end
    end

    ////////////////////
    // join words with their pcs

    // rdata arrives in the cycle after accept
    assign ir_lo = i_imem_rdata[XLEN-1:0];
    assign ir_hi = i_imem_rdata[2*XLEN-1:XLEN];

    assign o_fetch.slot_a = '{pc: pc_q, ir: ir_lo};
    assign o_fetch.slot_b = '{pc: pc_q + addr_t'(WORD_BYTES), ir: ir_hi};

    // slot b only when the line had room for two
    assign o_fetch.valid = {valid_q & pair_q, valid_q};

endmodule

`default_nettype wire

// ==== verilog/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    import isa_pkg::*;

    ////////////////////
    // instruction buffer sizing
    localparam int IBUF_DEPTH       = 8;
    localparam int IBUF_PTR_W       = $clog2(IBUF_DEPTH);
    // full when fewer slots than this are free
    // covers the pair in flight plus the pair being requested
    localparam int IBUF_FULL_MARGIN = 4;

    // one queued instruction with its pc
    typedef struct packed {
        addr_t pc;
        inst_t ir;
    } inst_slot_t;

    // decoder take count, 0..2
    typedef logic [1:0] take_t;

endpackage

`default_nettype wire

// ==== verilog/inst_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_buffer import frontend_pkg::*; (
    input  wire         clk,
    input  wire         i_arst_n,
    fetch_if.buffer     i_fetch,
    input  wire         i_flush,        // drop everything queued
    input  wire take_t  i_take,         // instructions consumed this edge
    output inst_slot_t  o_head_a,       // oldest
    output inst_slot_t  o_head_b,
    output logic [1:0]  o_valid,
    output logic        o_full
);

    inst_slot_t              mem [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0]   head_q;
    logic [IBUF_PTR_W-1:0]   tail_q;
    logic [IBUF_PTR_W:0]     count_q;    // 0..IBUF_DEPTH
    logic [IBUF_PTR_W-1:0]   head_nx;    // second head slot
    logic [IBUF_PTR_W-1:0]   tail_nx;    // second write slot
    logic [1:0]              n_wr;
    logic [IBUF_PTR_W:0]     free_cnt;

    ////////////////////
    // write side

    // slot b is only ever valid together with slot a
    assign n_wr    = {1'b0, i_fetch.valid[0]} + {1'b0, i_fetch.valid[1]};
    assign tail_nx = tail_q + 1'b1;

    always_ff @(posedge clk) begin
        if (i_fetch.valid[0]) begin
            mem[tail_q] <= i_fetch.slot_a;
        end
        if (i_fetch.valid[1]) begin
            mem[tail_nx] <= i_fetch.slot_b;
        end
    end

    ////////////////////
    // pointers and count

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (i_flush) begin
            // redirect, anything written this edge is stale too
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + IBUF_PTR_W'(i_take);
            tail_q  <= tail_q + IBUF_PTR_W'(n_wr);
            count_q <= count_q + (IBUF_PTR_W + 1)'(n_wr) - (IBUF_PTR_W + 1)'(i_take);
        end
    end

    ////////////////////
    // read side

    assign head_nx  = head_q + 1'b1;   // wraps with the pointer width

    assign o_head_a = mem[head_q];
    assign o_head_b = mem[head_nx];

    // bit 1 implies bit 0 by construction
    assign o_valid[0] = count_q != '0;
    assign o_valid[1] = count_q > (IBUF_PTR_W + 1)'(1);

    // hold fetch early enough for two pairs still to land
    assign free_cnt = (IBUF_PTR_W + 1)'(IBUF_DEPTH) - count_q;
    assign o_full   = free_cnt < (IBUF_PTR_W + 1)'(IBUF_FULL_MARGIN);

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    ////////////////////
    // word and line geometry
    localparam int XLEN       = 32;
    localparam int WORD_BYTES = 4;                      // pc step per instruction
    localparam int LINE_WORDS = 4;                      // words in one 16-byte line
    localparam int WORD_OFS_W = $clog2(WORD_BYTES);     // byte offset bits
    localparam int LINE_IDX_W = $clog2(LINE_WORDS);     // word index bits in a line

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] inst_t;

    // first fetch address out of reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

endpackage

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_gen import isa_pkg::*; (
    input  wire         clk,
    input  wire         i_arst_n,
    input  wire         i_br_valid,     // branch resolved, one-cycle pulse
    input  wire addr_t  i_br_target,
    input  wire         i_imem_ready,
    input  wire         i_full,         // instruction buffer cannot take more
    output logic        o_imem_req,
    output addr_t       o_pc,
    output logic        o_pair          // two words in this fetch
);

    addr_t pc_q;
    addr_t pc_step;
    logic  run_q;
    logic  last_word;
    logic  accept;

    ////////////////////
    // next-pc rule

    // last word of the line only gets one instruction
    assign last_word = pc_q[WORD_OFS_W +: LINE_IDX_W] == LINE_IDX_W'(LINE_WORDS - 1);
    assign pc_step   = last_word ? addr_t'(WORD_BYTES) : addr_t'(2 * WORD_BYTES);

    assign o_imem_req = run_q & ~i_full;
    assign accept     = o_imem_req & i_imem_ready;

    // fetch starts one edge out of reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // redirect wins over the sequential step
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= RESET_PC;
        end else if (i_br_valid) begin
            pc_q <= i_br_target;
        end else if (accept) begin
            pc_q <= pc_q + pc_step;
        end
        // no accept -> hold, addr stays put while stalled
    end

    assign o_pc   = pc_q;
    assign o_pair = ~last_word;

endmodule

`default_nettype wire
